/* hdl/vec_pkg.sv */
// vector list format
`default_nettype none

package vec_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int COORD_WIDTH = 8;                    // one screen axis
    localparam int ADR_WIDTH   = 8;                    // 256 list entries
    localparam int WORD_WIDTH  = 2 * COORD_WIDTH + 2;  // x, y and two flags

    // entry layout, x in the top bits
    localparam int X_MSB    = WORD_WIDTH - 1;
    localparam int X_LSB    = X_MSB - COORD_WIDTH + 1;
    localparam int Y_MSB    = X_LSB - 1;
    localparam int Y_LSB    = Y_MSB - COORD_WIDTH + 1;
    localparam int LINE_BIT = 1;
    localparam int POS_BIT  = 0;   // pos and line together end the list

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef logic [COORD_WIDTH-1:0] coord_t;     // unsigned screen coordinate
    typedef logic [ADR_WIDTH-1:0]   vec_adr_t;
    typedef logic [WORD_WIDTH-1:0]  vec_word_t;  // one list entry

endpackage

`default_nettype wire

/* hdl/draw_pkg.sv */
// drawing side types
`default_nettype none

package draw_pkg;

    // one extra bit so coordinate differences stay in range
    localparam int BRES_WIDTH   = vec_pkg::COORD_WIDTH + 1;
    localparam int ERR_WIDTH    = BRES_WIDTH + 2;  // room for twice the error term
    localparam int FRAME_W      = 256;             // pixels per row
    localparam int FB_ADR_WIDTH = 16;

    typedef logic signed [BRES_WIDTH-1:0] bres_coord_t;
    typedef logic signed [ERR_WIDTH-1:0]  bres_err_t;
    typedef logic [FB_ADR_WIDTH-1:0]      fb_adr_t;     // row * FRAME_W + column

    ////////////////////////////////////////
    // state machines
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        SEQ_IDLE,   // waiting for run
        SEQ_FETCH,  // ram read in flight
        SEQ_LOAD,
        SEQ_SEND,
        SEQ_WAIT,   // segment being drawn
        SEQ_NEXT
    } seq_state_t;

    typedef enum logic {
        LINE_IDLE,
        LINE_STEP
    } line_state_t;

endpackage

`default_nettype wire

/* hdl/line_if.sv */
// segment request channel
`timescale 1ns/1ns
`default_nettype none

interface line_if;

    logic                  go;    // one cycle pulse
    draw_pkg::bres_coord_t stax;
    draw_pkg::bres_coord_t stay;
    draw_pkg::bres_coord_t endx;
    draw_pkg::bres_coord_t endy;
    logic                  done;  // pulse after the last pixel

    // endpoints stay stable from go until done
    modport seq (output go, stax, stay, endx, endy, input done);
    modport drawer (input go, stax, stay, endx, endy, output done);

endinterface

`default_nettype wire

/* hdl/vector_list_ram.sv */
// vector list memory
`timescale 1ns/1ns
`default_nettype none

module vector_list_ram (
    input  wire                     clk,
    input  wire                     we,
    input  wire vec_pkg::vec_adr_t  wr_adr,
    input  wire vec_pkg::vec_word_t wr_data,
    input  wire vec_pkg::vec_adr_t  rd_adr,
    output vec_pkg::vec_word_t      rd_data
);

    import vec_pkg::*;

    vec_word_t mem [2**ADR_WIDTH];

    // load port, open at any time
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_adr] <= wr_data;
        end
    end

    // registered read for the sequencer
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_adr];  // old data on a same-cycle write
    end

endmodule

`default_nettype wire

/* hdl/vector_manage.sv */
// vector list sequencer
`timescale 1ns/1ns
`default_nettype none

module vector_manage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     run,
    output vec_pkg::vec_adr_t       adr,
    input  wire vec_pkg::vec_word_t entry,
    line_if.seq                     seg,
    output logic                    pass_done
);

    import vec_pkg::*;
    import draw_pkg::*;

    seq_state_t  state;
    seq_state_t  state_nxt;
    bres_coord_t pen_x;     // previous pen position
    bres_coord_t pen_y;
    bres_coord_t new_x;
    bres_coord_t new_y;
    logic        is_pos;
    logic        is_line;
    logic        is_term;
    logic        pen_move;

    ////////////////////////////////////////
    // entry decode
    ////////////////////////////////////////
    assign new_x    = {1'b0, entry[X_MSB:X_LSB]};  // zero extend into signed
    assign new_y    = {1'b0, entry[Y_MSB:Y_LSB]};
    assign is_pos   = entry[POS_BIT];
    assign is_line  = entry[LINE_BIT];
    assign is_term  = is_pos && is_line;
    assign pen_move = is_pos ^ is_line;  // exactly one flag

    assign pass_done = (state == SEQ_LOAD) && is_term;
    assign seg.go    = (state == SEQ_SEND);

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE:  state_nxt = run ? SEQ_FETCH : SEQ_IDLE;
            SEQ_FETCH: state_nxt = SEQ_LOAD;
            SEQ_LOAD:  state_nxt = is_term ? SEQ_IDLE : SEQ_SEND;
            SEQ_SEND:  state_nxt = SEQ_WAIT;
            SEQ_WAIT:  state_nxt = seg.done ? SEQ_NEXT : SEQ_WAIT;
            SEQ_NEXT:  state_nxt = SEQ_FETCH;
            default:   state_nxt = SEQ_IDLE;
        endcase
    end

    // state, list address and pen
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            adr   <= '0;
            pen_x <= '0;
            pen_y <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                SEQ_IDLE: begin
                    adr   <= '0;  // every pass starts at the top
                    pen_x <= '0;
                    pen_y <= '0;
                end
                SEQ_LOAD: begin
                    if (pen_move) begin
                        pen_x <= new_x;
                        pen_y <= new_y;
                    end
                end
                SEQ_NEXT: adr <= adr + 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // segment endpoints
    ////////////////////////////////////////
    // neither flag leaves the last segment in place, so it is drawn again
    always_ff @(posedge clk) begin
        if (state == SEQ_LOAD) begin
            if (is_pos && !is_line) begin  // single point
                seg.stax <= new_x;
                seg.stay <= new_y;
                seg.endx <= new_x;
                seg.endy <= new_y;
            end else if (is_line && !is_pos) begin
                seg.stax <= pen_x;  // from the pen
                seg.stay <= pen_y;
                seg.endx <= new_x;
                seg.endy <= new_y;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/bresenham.sv */
// bresenham line drawer
`timescale 1ns/1ns
`default_nettype none

module bresenham (
    input  wire             clk,
    input  wire             rst,
    line_if.drawer          seg,
    output logic            pix_valid,
    output vec_pkg::coord_t pix_x,
    output vec_pkg::coord_t pix_y
);

    import vec_pkg::*;
    import draw_pkg::*;

    line_state_t state;
    bres_coord_t cur_x;
    bres_coord_t cur_y;
    bres_coord_t end_x;
    bres_coord_t end_y;
    bres_coord_t diff_x;
    bres_coord_t diff_y;
    bres_err_t   go_dx;    // |dx| of the new segment
    bres_err_t   go_dy;    // -|dy|
    bres_err_t   dx;
    bres_err_t   dy;
    bres_err_t   err;
    bres_err_t   e2;
    bres_err_t   err_nxt;
    logic        neg_x;    // step direction, set for decreasing
    logic        neg_y;
    logic        step_x;
    logic        step_y;
    logic        at_end;

    ////////////////////////////////////////
    // setup from the request
    ////////////////////////////////////////
    assign diff_x = seg.endx - seg.stax;
    assign diff_y = seg.endy - seg.stay;
    assign go_dx  = bres_err_t'((diff_x < 0) ? -diff_x : diff_x);
    assign go_dy  = bres_err_t'((diff_y < 0) ? diff_y : -diff_y);

    // error term step, all octants
    assign e2      = err <<< 1;
    assign step_x  = (e2 >= dy);
    assign step_y  = (e2 <= dx);
    assign err_nxt = err + (step_x ? dy : '0) + (step_y ? dx : '0);
    assign at_end  = (cur_x == end_x) && (cur_y == end_y);

    assign pix_valid = (state == LINE_STEP);  // current point is on the line
    assign pix_x     = coord_t'(cur_x);
    assign pix_y     = coord_t'(cur_y);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= LINE_IDLE;
            seg.done <= 1'b0;
        end else begin
            seg.done <= 1'b0;
            case (state)
                LINE_IDLE: begin
                    if (seg.go) begin
                        state <= LINE_STEP;
                    end
                end
                LINE_STEP: begin
                    if (at_end) begin
                        state    <= LINE_IDLE;
                        seg.done <= 1'b1;  // cycle after the end pixel
                    end
                end
                default: state <= LINE_IDLE;
            endcase
        end
    end

    // position and error term
    always_ff @(posedge clk) begin
        if (state == LINE_IDLE && seg.go) begin
            cur_x <= seg.stax;
            cur_y <= seg.stay;
            end_x <= seg.endx;
            end_y <= seg.endy;
            dx    <= go_dx;
            dy    <= go_dy;
            err   <= go_dx + go_dy;
            neg_x <= (diff_x < 0);
            neg_y <= (diff_y < 0);
        end else if (state == LINE_STEP && !at_end) begin
            err <= err_nxt;
            if (step_x) begin
                cur_x <= neg_x ? cur_x - 1'b1 : cur_x + 1'b1;
            end
            if (step_y) begin
                cur_y <= neg_y ? cur_y - 1'b1 : cur_y + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_writer.sv */
// frame buffer pixel writer
`timescale 1ns/1ns
`default_nettype none

module pixel_writer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  pix_valid,
    input  wire vec_pkg::coord_t pix_x,
    input  wire vec_pkg::coord_t pix_y,
    output logic                 pixel_we,
    output draw_pkg::fb_adr_t    pixel_adr
);

    import vec_pkg::*;
    import draw_pkg::*;

    coord_t last_x;      // last pixel written
    coord_t last_y;
    logic   have_last;
    logic   repeat_pix;
    logic   accept;

    // segments chained end to start repeat one pixel
    assign repeat_pix = have_last && (pix_x == last_x) && (pix_y == last_y);
    assign accept     = pix_valid && !repeat_pix;

    always_ff @(posedge clk) begin
        if (rst) begin
            have_last <= 1'b0;
            pixel_we  <= 1'b0;
        end else begin
            pixel_we <= accept;
            if (accept) begin
                have_last <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            last_x    <= pix_x;
            last_y    <= pix_y;
            pixel_adr <= fb_adr_t'(pix_y * FRAME_W + pix_x);  // linear, row major
        end
    end

endmodule

`default_nettype wire

/* hdl/vector_display.sv */
// vector display engine
`timescale 1ns/1ns
`default_nettype none

module vector_display (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    run,
    input  wire                    load_we,
    input  wire vec_pkg::vec_adr_t load_adr,
    input  wire vec_pkg::coord_t   load_x,
    input  wire vec_pkg::coord_t   load_y,
    input  wire                    load_line,
    input  wire                    load_pos,
    output logic                   pixel_we,
    output draw_pkg::fb_adr_t      pixel_adr,
    output logic                   pass_done
);

    import vec_pkg::*;

    vec_word_t load_word;
    vec_word_t entry;
    vec_adr_t  rd_adr;
    logic      pix_valid;
    coord_t    pix_x;
    coord_t    pix_y;

    line_if seg_if ();

    assign load_word = {load_x, load_y, load_line, load_pos};  // same order as the entry layout

    vector_list_ram u_ram (
        .clk     (clk),
        .we      (load_we),
        .wr_adr  (load_adr),
        .wr_data (load_word),
        .rd_adr  (rd_adr),
        .rd_data (entry)
    );

    vector_manage u_manage (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .adr       (rd_adr),
        .entry     (entry),
        .seg       (seg_if),
        .pass_done (pass_done)
    );

    bresenham u_line (
        .clk       (clk),
        .rst       (rst),
        .seg       (seg_if),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y)
    );

    pixel_writer u_writer (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pixel_we  (pixel_we),
        .pixel_adr (pixel_adr)
    );

endmodule

`default_nettype wire

/* tb/vector_display_assertions.sv */
// pixel stream and pass checks
`timescale 1ns/1ns
`default_nettype none

module vector_display_assertions (
    input wire                        clk,
    input wire                        rst,
    input wire                        run,
    input wire                        pixel_we,
    input wire draw_pkg::fb_adr_t     pixel_adr,
    input wire                        pass_done,
    input wire draw_pkg::seq_state_t  seq_state,
    input wire draw_pkg::line_state_t line_state
);

    import draw_pkg::*;

    int      assert_errors = 0;
    bit      rst_q;
    bit      have_prev;  // earlier write in this pass
    bit      have_last;  // earlier write since reset
    fb_adr_t prev_adr;

    function automatic bit adjacent(input fb_adr_t a, input fb_adr_t b);
        int dr, dc;
        dr = int'(a[15:8]) - int'(b[15:8]);
        dc = int'(a[7:0]) - int'(b[7:0]);
        return (dr >= -1) && (dr <= 1) && (dc >= -1) && (dc <= 1);
    endfunction

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            have_prev <= 1'b0;
            have_last <= 1'b0;
        end else begin
            if (pixel_we) begin
                have_prev <= 1'b1;
                have_last <= 1'b1;
                prev_adr  <= pixel_adr;
            end
            if (pass_done) have_prev <= 1'b0;  // next pass opens with a pos entry
        end
    end

    pass_pulse: assert property (@(posedge clk) disable iff (rst) pass_done |=> !pass_done)
        else begin
            assert_errors = assert_errors + 1;
            $error("pass_done longer than one cycle");
        end

    reset_quiet: assert property (@(posedge clk) (rst && rst_q) |-> !pixel_we)
        else begin
            assert_errors = assert_errors + 1;
            $error("pixel written during reset");
        end

    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (seq_state == SEQ_IDLE && !run) |-> (line_state == LINE_IDLE && !pixel_we))
        else begin
            assert_errors = assert_errors + 1;
            $error("pixel written while the engine is idle");
        end

    step_adjacent: assert property (@(posedge clk) disable iff (rst)
        (pixel_we && have_prev) |-> adjacent(pixel_adr, prev_adr))
        else begin
            assert_errors = assert_errors + 1;
            $error("consecutive writes are not adjacent");
        end

    no_repeat: assert property (@(posedge clk) disable iff (rst)
        (pixel_we && have_last) |-> pixel_adr != prev_adr)
        else begin
            assert_errors = assert_errors + 1;
            $error("same address written twice in a row");
        end

endmodule

bind vector_display vector_display_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .pixel_we   (pixel_we),
    .pixel_adr  (pixel_adr),
    .pass_done  (pass_done),
    .seq_state  (u_manage.state),
    .line_state (u_line.state)
);

`default_nettype wire

/* tb/vector_display_tb.sv */
// vector display testbench
`timescale 1ns/1ns
`default_nettype none

module vector_display_tb;

    import vec_pkg::*;
    import draw_pkg::*;

    localparam int LIST_MAX = 22;  // pos, 20 lines, terminator
    localparam int PASSES   = 5;
    localparam int WATCHDOG = PASSES * LIST_MAX * (256 + 8) + 2000;

    logic        clk;
    logic        rst;
    logic        run;
    logic        load_we;
    vec_adr_t    load_adr;
    coord_t      load_x;
    coord_t      load_y;
    logic        load_line;
    logic        load_pos;
    logic        pixel_we;
    fb_adr_t     pixel_adr;
    logic        pass_done;

    bit          expected [FRAME_W * FRAME_W];
    bit          written [FRAME_W * FRAME_W];
    int          list_x [LIST_MAX];
    int          list_y [LIST_MAX];
    bit          list_line [LIST_MAX];
    bit          list_pos [LIST_MAX];
    int          list_len = 0;
    int          errors = 0;
    int          assert_count;
    int          last_adr = 0;
    bit          any_written = 1'b0;
    int          carry_adr = 0;     // still on screen from the pass before
    bit          carry_valid = 1'b0;
    int unsigned seed;
    int          r;

    vector_display dut0 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .load_we   (load_we),
        .load_adr  (load_adr),
        .load_x    (load_x),
        .load_y    (load_y),
        .load_line (load_line),
        .load_pos  (load_pos),
        .pixel_we  (pixel_we),
        .pixel_adr (pixel_adr),
        .pass_done (pass_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("ERROR: test timed out after %0d cycles", WATCHDOG);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    task automatic plot_line(input int x0, input int y0, input int x1, input int y1);
        int dx, dy, sx, sy, err, e2, x, y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        sx  = (x1 >= x0) ? 1 : -1;
        sy  = (y1 >= y0) ? 1 : -1;
        x   = x0;
        y   = y0;
        err = dx + dy;
        forever begin
            expected[y * FRAME_W + x] = 1'b1;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endtask

    task automatic build_expected();
        int i, pen_x, pen_y;
        foreach (expected[a]) expected[a] = 1'b0;
        pen_x = 0;
        pen_y = 0;
        for (i = 0; i < list_len; i++) begin
            if (list_pos[i] && list_line[i]) break;  // terminator
            if (list_pos[i]) plot_line(list_x[i], list_y[i], list_x[i], list_y[i]);
            else if (list_line[i]) plot_line(pen_x, pen_y, list_x[i], list_y[i]);
            pen_x = list_x[i];
            pen_y = list_y[i];
        end
    endtask

    // frame buffer writes sampled mid cycle
    always @(negedge clk) begin
        if (!rst && pixel_we === 1'b1) begin
            written[pixel_adr] = 1'b1;
            if (!expected[pixel_adr]) begin
                errors++;
                $display("FAIL %0t: pixel (%0d,%0d) written outside the expected set",
                         $time, pixel_adr % FRAME_W, pixel_adr / FRAME_W);
            end
            last_adr    = pixel_adr;
            any_written = 1'b1;
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    task automatic put_entry(input int idx, input int x, input int y,
                             input bit line, input bit pos);
        load_we        = 1'b1;
        load_adr       = vec_adr_t'(idx);
        load_x         = coord_t'(x);
        load_y         = coord_t'(y);
        load_line      = line;
        load_pos       = pos;
        list_x[idx]    = x;
        list_y[idx]    = y;
        list_line[idx] = line;
        list_pos[idx]  = pos;
        list_len       = idx + 1;
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic clear_written();
        foreach (written[a]) written[a] = 1'b0;
        carry_adr   = last_adr;
        carry_valid = any_written && list_pos[0] &&
                      (last_adr == list_y[0] * FRAME_W + list_x[0]);
    endtask

    task automatic check_pass(input string name);
        int a;
        for (a = 0; a < FRAME_W * FRAME_W; a++) begin
            if (expected[a] && !written[a] && !(carry_valid && a == carry_adr)) begin
                errors++;
                $display("FAIL %0t: %s missing pixel (%0d,%0d)", $time, name,
                         a % FRAME_W, a / FRAME_W);
            end
        end
    endtask

    task automatic wait_pass();
        @(negedge clk);
        while (pass_done !== 1'b1) @(negedge clk);
    endtask

    task automatic draw_and_check(input string name, input int passes);
        int p;
        build_expected();
        clear_written();
        run = 1'b1;
        for (p = 0; p < passes; p++) begin
            wait_pass();
            check_pass(name);
            clear_written();
        end
        run = 1'b0;
        repeat (20) @(negedge clk);  // quiet engine while idle
    endtask

    task automatic load_hand_list();
        put_entry(0, 40, 40, 1'b0, 1'b1);
        put_entry(1, 80, 40, 1'b1, 1'b0);    // horizontal
        put_entry(2, 80, 90, 1'b1, 1'b0);    // vertical
        put_entry(3, 120, 130, 1'b1, 1'b0);  // diagonal down
        put_entry(4, 160, 90, 1'b1, 1'b0);   // diagonal up
        put_entry(5, 170, 150, 1'b1, 1'b0);  // steep +x +y
        put_entry(6, 160, 210, 1'b1, 1'b0);  // steep -x +y
        put_entry(7, 150, 140, 1'b1, 1'b0);  // steep -x -y
        put_entry(8, 158, 60, 1'b1, 1'b0);   // steep +x -y
        put_entry(9, 30, 70, 1'b1, 1'b0);
        put_entry(10, 0, 0, 1'b1, 1'b1);
    endtask

    task automatic load_random_list();
        int i;
        put_entry(0, $urandom_range(255), $urandom_range(255), 1'b0, 1'b1);
        for (i = 1; i <= 20; i++) begin
            put_entry(i, $urandom_range(255), $urandom_range(255), 1'b1, 1'b0);
        end
        put_entry(21, 0, 0, 1'b1, 1'b1);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        seed      = $urandom(20661);
        rst       = 1'b1;
        run       = 1'b0;
        load_we   = 1'b0;
        load_adr  = '0;
        load_x    = '0;
        load_y    = '0;
        load_line = 1'b0;
        load_pos  = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        load_hand_list();
        draw_and_check("hand list", 2);  // second pass with run held high
        for (r = 0; r < 3; r++) begin
            load_random_list();          // list rewritten between passes
            draw_and_check("random list", 1);
        end
        assert_count = dut0.u_assertions.assert_errors;
        $display("bitmap errors: %0d, assertion errors: %0d", errors, assert_count);
        if (errors == 0 && assert_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vector_display.f */
hdl/vec_pkg.sv
hdl/draw_pkg.sv
hdl/line_if.sv
hdl/vector_list_ram.sv
hdl/vector_manage.sv
hdl/bresenham.sv
hdl/pixel_writer.sv
hdl/vector_display.sv
tb/vector_display_assertions.sv
tb/vector_display_tb.sv

/* Bender.yml */
package:
  name: vector_display

sources:
  - files:
      - hdl/vec_pkg.sv
      - hdl/draw_pkg.sv
      - hdl/line_if.sv
      - hdl/vector_list_ram.sv
      - hdl/vector_manage.sv
      - hdl/bresenham.sv
      - hdl/pixel_writer.sv
      - hdl/vector_display.sv
  - target: test
    files:
      - tb/vector_display_assertions.sv
      - tb/vector_display_tb.sv
